// File: include/fifo_cfg.svh
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// queue geometry.
`define FIFO_DEPTH        16
`define FIFO_DATA_WIDTH   16
`define FIFO_ALMOST_FULL  14
`define FIFO_ALMOST_EMPTY 2

// register map, byte offsets.
`define AXIL_ADDR_WIDTH   4
`define FIFO_ADDR_PUSH    4'h0
`define FIFO_ADDR_POP     4'h4
`define FIFO_ADDR_STATUS  4'h8
`define FIFO_ADDR_CTRL    4'hC

`endif

// File: verilog/fifo_pkg.sv
`include "fifo_cfg.svh"

package fifo_pkg;

    // count must reach FIFO_DEPTH itself, hence the extra bit.
    localparam int COUNT_W = $clog2(`FIFO_DEPTH) + 1;

    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

    typedef logic [COUNT_W-1:0] count_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // ========================================
    // status register layout
    // ========================================
    typedef struct packed {
        logic [11:0]         rsvd_hi;       // bits 31:20.
        logic                almost_empty;  // bit 19.
        logic                almost_full;   // bit 18.
        logic                empty;         // bit 17.
        logic                full;          // bit 16.
        logic [15-COUNT_W:0] rsvd_lo;       // bits 15:5.
        count_t              count;         // bits 4:0.
    } status_t;

endpackage

// File: verilog/axil_push_port.sv
`include "fifo_cfg.svh"

module axil_push_port (
    input  logic                        clk,
    input  logic                        rst_n,

    // write address channel
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,

    // write data channel
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [31:0]                 wdata,

    // write response channel
    output logic                        bvalid,
    input  logic                        bready,
    output fifo_pkg::resp_t             bresp,

    // fifo side
    input  logic                        full,
    output logic                        push,
    output fifo_pkg::data_t             push_data,
    output logic                        flush
);

    import fifo_pkg::*;

    logic  wr_fire;
    logic  is_push;
    logic  is_ctrl;
    resp_t resp_next;

    // ========================================
    // handshake and decode
    // ========================================

    // both channels are taken in the same cycle, and only with no response pending.
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign is_push = (awaddr == `FIFO_ADDR_PUSH);
    assign is_ctrl = (awaddr == `FIFO_ADDR_CTRL);

    // fifo strobes, qualified by the handshake.
    assign push      = wr_fire && is_push && !full;  // a push into a full fifo is dropped.
    assign push_data = wdata[$bits(data_t)-1:0];
    assign flush     = wr_fire && is_ctrl && wdata[0];

    always_comb begin
        if (is_push && !full) begin
            resp_next = OKAY;
        end else if (is_ctrl) begin
            resp_next = OKAY;  // ctrl write is accepted with bit 0 clear too.
        end else begin
            resp_next = SLVERR;
        end
    end

    // ========================================
    // write response
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            bresp  <= OKAY;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= resp_next;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;  // response taken.
            end
        end
    end

endmodule

// File: verilog/sync_fifo.sv
`include "fifo_cfg.svh"

module sync_fifo #(
    parameter int DEPTH         = `FIFO_DEPTH,
    parameter int AFULL_THRESH  = `FIFO_ALMOST_FULL,
    parameter int AEMPTY_THRESH = `FIFO_ALMOST_EMPTY
) (
    input  logic             clk,
    input  logic             rst_n,

    // write side
    input  logic             push,
    input  fifo_pkg::data_t  push_data,

    // read side
    input  logic             pop,
    output fifo_pkg::data_t  pop_data,

    input  logic             flush,

    // fill state
    output fifo_pkg::count_t count,
    output logic             full,
    output logic             empty,
    output logic             almost_full,
    output logic             almost_empty
);

    import fifo_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    data_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // wraps at DEPTH, so depths that are not a power of two also work.
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ========================================
    // storage
    // ========================================

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop && !flush) begin
            pop_data <= mem[rd_ptr];  // head word, valid the cycle after pop.
        end
    end

    // ========================================
    // pointers and count
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;  // flush wins over push and pop.
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together.
            endcase
        end
    end

    // flags follow the count.
    assign full         = (count == count_t'(DEPTH));
    assign empty        = (count == '0);
    assign almost_full  = (count >= count_t'(AFULL_THRESH));
    assign almost_empty = (count <= count_t'(AEMPTY_THRESH));

endmodule

// File: verilog/axil_pop_port.sv
`include "fifo_cfg.svh"

module axil_pop_port (
    input  logic                        clk,
    input  logic                        rst_n,

    // read address channel
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,

    // read data channel
    output logic                        rvalid,
    input  logic                        rready,
    output logic [31:0]                 rdata,
    output fifo_pkg::resp_t             rresp,

    // fifo side
    output logic                        pop,
    input  fifo_pkg::data_t             pop_data,
    input  fifo_pkg::count_t            count,
    input  logic                        full,
    input  logic                        empty,
    input  logic                        almost_full,
    input  logic                        almost_empty
);

    import fifo_pkg::*;

    typedef enum logic [1:0] {
        SEL_ZERO,
        SEL_POP,
        SEL_STATUS
    } rsel_t;

    logic    rd_fire;
    logic    is_pop;
    logic    is_status;
    status_t status_now;
    status_t status_q;
    rsel_t   rsel_q;

    // ========================================
    // handshake and decode
    // ========================================

    assign arready = !rvalid;  // one read in flight.
    assign rd_fire = arvalid && arready;

    assign is_pop    = (araddr == `FIFO_ADDR_POP);
    assign is_status = (araddr == `FIFO_ADDR_STATUS);

    assign pop = rd_fire && is_pop && !empty;

    always_comb begin
        status_now              = '0;
        status_now.count        = count;
        status_now.full         = full;
        status_now.empty        = empty;
        status_now.almost_full  = almost_full;
        status_now.almost_empty = almost_empty;
    end

    // ========================================
    // read response
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            rresp  <= OKAY;
            rsel_q <= SEL_ZERO;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
                if (is_pop && !empty) begin
                    rresp  <= OKAY;
                    rsel_q <= SEL_POP;
                end else if (is_status) begin
                    rresp  <= OKAY;
                    rsel_q <= SEL_STATUS;
                end else begin
                    rresp  <= SLVERR;  // empty pop or unmapped address.
                    rsel_q <= SEL_ZERO;
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // status is captured in the AR cycle.
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            status_q <= status_now;
        end
    end

    // pop_data holds until the next pop, which waits for rready.
    always_comb begin
        case (rsel_q)
            SEL_POP:    rdata = 32'(pop_data);
            SEL_STATUS: rdata = status_q;
            default:    rdata = '0;
        endcase
    end

endmodule

// File: verilog/fifo_axil_top.sv
`include "fifo_cfg.svh"

module fifo_axil_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // write channels
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [31:0]                 wdata,
    output logic                        bvalid,
    input  logic                        bready,
    output fifo_pkg::resp_t             bresp,

    // read channels
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [31:0]                 rdata,
    output fifo_pkg::resp_t             rresp
);

    import fifo_pkg::*;

    logic   push;
    data_t  push_data;
    logic   flush;
    logic   pop;
    data_t  pop_data;
    count_t count;
    logic   full;
    logic   empty;
    logic   almost_full;
    logic   almost_empty;

    axil_push_port axil_push_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .full      (full),
        .push      (push),
        .push_data (push_data),
        .flush     (flush)
    );

    sync_fifo sync_fifo_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (push),
        .push_data    (push_data),
        .pop          (pop),
        .pop_data     (pop_data),
        .flush        (flush),
        .count        (count),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty)
    );

    axil_pop_port axil_pop_port_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .pop          (pop),
        .pop_data     (pop_data),
        .count        (count),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty)
    );

endmodule

// File: dv/fifo_axil_tb.sv
`include "fifo_cfg.svh"

module fifo_axil_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import fifo_pkg::*;

    typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;

    localparam logic [31:0] SEED = 32'hcf9d_1223;
    localparam int MAX_CYCLES = 20000;  // about 600 transactions of under 10 cycles.
    localparam int SETTLE_NS  = 25;     // a quarter period after the falling edge.

    logic        clk;
    logic        rst_n;
    logic        awvalid;
    logic        awready;
    addr_t       awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    resp_t       bresp;
    logic        arvalid;
    logic        arready;
    addr_t       araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    resp_t       rresp;

    data_t model_q[$];
    int    error_count;
    int    check_count;
    int    cycle_count = 0;

    fifo_axil_top fifo_axil_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a bus response never arrived", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ========================================
    // reference model
    // ========================================

    function automatic status_t model_status();
        logic [31:0] word;
        int          n;
        n        = model_q.size();
        word     = 32'(n);  // count sits in bits 4:0.
        word[16] = (n == `FIFO_DEPTH);
        word[17] = (n == 0);
        word[18] = (n >= `FIFO_ALMOST_FULL);
        word[19] = (n <= `FIFO_ALMOST_EMPTY);
        return status_t'(word);
    endfunction

    function automatic resp_t model_push(input data_t d);
        if (model_q.size() >= `FIFO_DEPTH) begin
            return SLVERR;  // word is dropped.
        end
        model_q.push_back(d);
        return OKAY;
    endfunction

    function automatic resp_t model_pop(output data_t d);
        if (model_q.size() == 0) begin
            d = '0;
            return SLVERR;
        end
        d = model_q.pop_front();
        return OKAY;
    endfunction

    // ========================================
    // compare tasks
    // ========================================

    task automatic check_resp(input resp_t exp, input resp_t act, input string what);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL @%0t: %s response expected %b, got %b", $time, what, exp, act);
        end
    endtask

    task automatic check_data(input data_t exp, input data_t act, input string what);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL @%0t: %s expected %h, got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_status(input status_t exp, input status_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL @%0t: status expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_signal(input logic exp, input logic act, input string what);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAIL @%0t: %s expected %b, got %b", $time, what, exp, act);
        end
    endtask

    // ========================================
    // bus tasks
    // ========================================

    // every task starts and ends on a falling edge.
    task automatic axil_write(input addr_t addr, input logic [31:0] data, output resp_t resp);
        int unsigned gap;
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        gap = $urandom_range(0, 2);  // data may trail the address.
        repeat (gap) @(negedge clk);
        wdata  = data;
        wvalid = 1'b1;
        #SETTLE_NS;  // ready follows the valids in the same cycle.
        check_signal(1'b1, awready, "awready");
        check_signal(1'b1, wready, "wready");
        @(negedge clk);
        check_signal(1'b1, bvalid, "bvalid after write handshake");
        check_signal(1'b0, awready, "awready with response pending");
        while (!bvalid) begin
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);  // hold off bready.
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, output resp_t resp, output logic [31:0] data);
        int unsigned gap;
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        #SETTLE_NS;
        check_signal(1'b1, arready, "arready");
        @(negedge clk);
        check_signal(1'b1, rvalid, "rvalid after read handshake");
        check_signal(1'b0, arready, "arready with response pending");
        while (!rvalid) begin
            @(negedge clk);
        end
        arvalid = 1'b0;
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge clk);
        resp   = rresp;
        data   = rdata;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic push_word(input data_t d);
        logic [31:0] word;
        resp_t       resp;
        word       = $urandom;  // upper half is ignored by the queue.
        word[15:0] = d;
        axil_write(`FIFO_ADDR_PUSH, word, resp);
        check_resp(model_push(d), resp, "push");
    endtask

    task automatic pop_word();
        logic [31:0] word;
        resp_t       resp;
        resp_t       exp_resp;
        data_t       exp_data;
        axil_read(`FIFO_ADDR_POP, resp, word);
        exp_resp = model_pop(exp_data);
        check_resp(exp_resp, resp, "pop");
        check_data(exp_data, data_t'(word[15:0]), "pop data");
        check_data('0, data_t'(word[31:16]), "pop upper half");
    endtask

    task automatic read_status();
        logic [31:0] word;
        resp_t       resp;
        axil_read(`FIFO_ADDR_STATUS, resp, word);
        check_resp(OKAY, resp, "status");
        check_status(model_status(), status_t'(word));
    endtask

    task automatic ctrl_write(input logic [31:0] word);
        resp_t resp;
        axil_write(`FIFO_ADDR_CTRL, word, resp);
        check_resp(OKAY, resp, "ctrl");
        if (word[0]) begin
            model_q.delete();
        end
    endtask

    task automatic bad_write();
        addr_t addr;
        resp_t resp;
        addr = `FIFO_ADDR_PUSH;
        while (addr == `FIFO_ADDR_PUSH || addr == `FIFO_ADDR_CTRL) begin
            addr = addr_t'($urandom_range(0, 15));
        end
        axil_write(addr, $urandom, resp);
        check_resp(SLVERR, resp, "unmapped write");
    endtask

    task automatic bad_read();
        addr_t       addr;
        resp_t       resp;
        logic [31:0] word;
        addr = `FIFO_ADDR_POP;
        while (addr == `FIFO_ADDR_POP || addr == `FIFO_ADDR_STATUS) begin
            addr = addr_t'($urandom_range(0, 15));
        end
        axil_read(addr, resp, word);
        check_resp(SLVERR, resp, "unmapped read");
        check_status('0, status_t'(word));  // zero data with the error.
    endtask

    // ========================================
    // tests
    // ========================================

    initial begin
        int unsigned op;
        void'($urandom(SEED));
        error_count = 0;
        check_count = 0;
        rst_n       = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        read_status();  // empty after reset.

        repeat (8) push_word(data_t'($urandom));  // words come back in order.
        repeat (8) pop_word();

        repeat (`FIFO_DEPTH + 1) push_word(data_t'($urandom));  // last one overflows.
        repeat (`FIFO_DEPTH) pop_word();

        pop_word();  // empty pop.

        // fill and drain, watching the watermarks.
        repeat (`FIFO_DEPTH) begin
            push_word(data_t'($urandom));
            read_status();
        end
        repeat (`FIFO_DEPTH) begin
            pop_word();
            read_status();
        end

        repeat (5) push_word(data_t'($urandom));
        ctrl_write(32'h0);  // bit 0 clear keeps the words.
        read_status();
        ctrl_write(32'h1);
        read_status();
        pop_word();

        repeat (500) begin
            op = $urandom_range(0, 99);
            if (op < 40) begin
                push_word(data_t'($urandom));
            end else if (op < 70) begin
                pop_word();
            end else if (op < 82) begin
                read_status();
            end else if (op < 88) begin
                ctrl_write($urandom);
            end else if (op < 94) begin
                bad_write();
            end else begin
                bad_read();
            end
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
verilog/fifo_pkg.sv
verilog/axil_push_port.sv
verilog/sync_fifo.sv
verilog/axil_pop_port.sv
verilog/fifo_axil_top.sv
dv/fifo_axil_tb.sv

// File: run.sh
#!/bin/sh
# build the queue testbench with Verilator and run it once.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module fifo_axil_tb -o fifo_axil_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/fifo_axil_sim)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qxF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
